// File: src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   typedef logic [31:0] addr_t;     // Byte address into instruction memory
   typedef logic [31:0] word_t;     // Instruction word or register data
   typedef logic [2:0]  reg_idx_t;  // 0 = eax ... 7 = edi

   typedef enum logic [3:0] {
      OP_NOP    = 4'h0,
      OP_MOV_RR = 4'h1,
      OP_MOV_RI = 4'h2,
      OP_ADD    = 4'h3,
      OP_ADD_RI = 4'h4,
      OP_SUB    = 4'h5,
      OP_AND    = 4'h6,
      OP_OR     = 4'h7,
      OP_XOR    = 4'h8,
      OP_JMP    = 4'h9
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_PASS_B = 3'd0,
      ALU_ADD    = 3'd1,
      ALU_SUB    = 3'd2,
      ALU_AND    = 3'd3,
      ALU_OR     = 3'd4,
      ALU_XOR    = 3'd5
   } alu_op_e;

   // Instruction fields
   localparam int OPC_MSB = 31;
   localparam int OPC_LSB = 28;
   localparam int DST_MSB = 27;
   localparam int DST_LSB = 25;
   localparam int SRC_MSB = 24;
   localparam int SRC_LSB = 22;
   localparam int IMM_MSB = 15;  // Sign bit of the immediate
   localparam int IMM_LSB = 0;

   localparam int    INSTR_BYTES = 4;
   localparam addr_t RESET_PC    = 32'h0000_0000;
   localparam int    NUM_REGS    = 8;

endpackage

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            redirect,
   input  cpu_pkg::addr_t  redirect_address,
   output logic            imem_valid,
   input  logic            imem_ready,
   output cpu_pkg::addr_t  imem_address,
   input  logic            imem_dp_valid,
   output logic            imem_dp_ready,
   input  cpu_pkg::word_t  imem_dp_read_data,
   output logic            f_valid,
   input  logic            f_ready,
   output cpu_pkg::word_t  f_instruction,
   output cpu_pkg::addr_t  f_pc
);
   import cpu_pkg::*;

   addr_t pc;            // Next request address
   addr_t req_pc;        // Address of the outstanding request
   addr_t jump_pc;
   logic  jump_pending;  // Redirect seen while a request was stuck on imem_ready
   logic  outstanding;
   logic  discard;       // Next response is stale
   logic  hold_valid;
   word_t hold_instr;
   addr_t hold_pc;
   logic  req_xfer;
   logic  resp_xfer;

   assign req_xfer      = imem_valid & imem_ready;
   assign resp_xfer     = imem_dp_valid & imem_dp_ready;
   assign imem_address  = pc;
   assign imem_dp_ready = ~hold_valid | f_ready | discard | redirect;

   assign f_valid       = hold_valid;
   assign f_instruction = hold_instr;
   assign f_pc          = hold_pc;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc           <= RESET_PC;
         imem_valid   <= 1'b0;
         outstanding  <= 1'b0;
         discard      <= 1'b0;
         jump_pending <= 1'b0;
         hold_valid   <= 1'b0;
      end else begin
         if (req_xfer) begin
            imem_valid   <= 1'b0;
            outstanding  <= 1'b1;
            pc           <= jump_pending ? jump_pc : pc + addr_t'(INSTR_BYTES);
            jump_pending <= 1'b0;
         end else if (resp_xfer) begin
            imem_valid  <= 1'b1;
            outstanding <= 1'b0;
         end else if (!outstanding) begin
            imem_valid <= 1'b1;
         end

         if (redirect) begin
            // A request already on the bus must finish at its old address
            if (imem_valid && !imem_ready) begin
               jump_pending <= 1'b1;
            end else begin
               pc <= redirect_address;
            end
            discard <= (outstanding & ~resp_xfer) | imem_valid;
         end else if (resp_xfer) begin
            discard <= 1'b0;
         end

         if (redirect)
            hold_valid <= 1'b0;
         else if (resp_xfer && !discard)
            hold_valid <= 1'b1;
         else if (f_ready)
            hold_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (req_xfer)
         req_pc <= pc;
      if (redirect)
         jump_pc <= redirect_address;
      if (resp_xfer && !discard && !redirect) begin
         hold_instr <= imem_dp_read_data;
         hold_pc    <= req_pc;
      end
   end

   // At most one request in flight
   a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      imem_valid |-> !outstanding);

endmodule

`default_nettype wire

// File: src/decode_unit.sv
`timescale 1ns/100ps
`default_nettype none

module decode_unit (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              redirect,
   input  logic              f_valid,
   output logic              f_ready,
   input  cpu_pkg::word_t    f_instruction,
   input  cpu_pkg::addr_t    f_pc,
   output logic              d_valid,
   input  logic              d_ready,
   output cpu_pkg::alu_op_e  d_alu_op,
   output cpu_pkg::reg_idx_t d_dst,
   output cpu_pkg::reg_idx_t d_src,
   output logic              d_uses_src,
   output logic              d_writes_dst,
   output logic              d_use_imm,
   output logic              d_jump,
   output cpu_pkg::word_t    d_imm,
   output cpu_pkg::addr_t    d_pc
);
   import cpu_pkg::*;

   opcode_e opc;
   alu_op_e alu_op;
   logic    uses_src;
   logic    writes_dst;
   logic    use_imm;
   logic    jump;

   assign opc     = opcode_e'(f_instruction[OPC_MSB:OPC_LSB]);
   assign f_ready = ~d_valid | d_ready;

   always_comb begin
      alu_op     = ALU_PASS_B;
      uses_src   = 1'b0;
      writes_dst = 1'b0;
      use_imm    = 1'b0;
      jump       = 1'b0;
      case (opc)
         OP_MOV_RR: begin
            uses_src   = 1'b1;
            writes_dst = 1'b1;
         end
         OP_MOV_RI: begin
            writes_dst = 1'b1;
            use_imm    = 1'b1;
         end
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
            uses_src   = 1'b1;
            writes_dst = 1'b1;
            alu_op     = (opc == OP_ADD) ? ALU_ADD :
                         (opc == OP_SUB) ? ALU_SUB :
                         (opc == OP_AND) ? ALU_AND :
                         (opc == OP_OR)  ? ALU_OR  : ALU_XOR;
         end
         OP_ADD_RI: begin
            alu_op     = ALU_ADD;
            writes_dst = 1'b1;
            use_imm    = 1'b1;
         end
         OP_JMP: begin
            jump    = 1'b1;
            use_imm = 1'b1;   // Word offset rides in op_b
         end
         default: ;           // NOP and unused codes
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         d_valid <= 1'b0;
      else if (redirect)
         d_valid <= 1'b0;
      else if (f_ready)
         d_valid <= f_valid;
   end

   always_ff @(posedge clk) begin
      if (f_valid && f_ready) begin
         d_alu_op     <= alu_op;
         d_dst        <= f_instruction[DST_MSB:DST_LSB];
         d_src        <= f_instruction[SRC_MSB:SRC_LSB];
         d_uses_src   <= uses_src;
         d_writes_dst <= writes_dst;
         d_use_imm    <= use_imm;
         d_jump       <= jump;
         d_imm        <= {{(31 - IMM_MSB){f_instruction[IMM_MSB]}},
                          f_instruction[IMM_MSB:IMM_LSB]};
         d_pc         <= f_pc;
      end
   end

endmodule

`default_nettype wire

// File: src/register_access.sv
`timescale 1ns/100ps
`default_nettype none

module register_access (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              redirect,
   input  logic              d_valid,
   output logic              d_ready,
   input  cpu_pkg::alu_op_e  d_alu_op,
   input  cpu_pkg::reg_idx_t d_dst,
   input  cpu_pkg::reg_idx_t d_src,
   input  logic              d_uses_src,
   input  logic              d_writes_dst,
   input  logic              d_use_imm,
   input  logic              d_jump,
   input  cpu_pkg::word_t    d_imm,
   input  cpu_pkg::addr_t    d_pc,
   output logic              r_valid,
   input  logic              r_ready,
   output cpu_pkg::alu_op_e  r_alu_op,
   output cpu_pkg::reg_idx_t r_dst,
   output logic              r_writes_dst,
   output logic              r_jump,
   output cpu_pkg::word_t    r_op_a,
   output cpu_pkg::word_t    r_op_b,
   output cpu_pkg::addr_t    r_pc,
   input  logic              wb_valid,
   input  cpu_pkg::reg_idx_t wb_reg,
   input  cpu_pkg::word_t    wb_data
);
   import cpu_pkg::*;

   word_t               regs [NUM_REGS];
   logic [NUM_REGS-1:0] pending;  // Write in flight past this stage
   logic [NUM_REGS-1:0] claimed;
   logic                stall;
   logic                d_xfer;
   logic                r_xfer;

   // The entry in the operand register is not yet marked pending
   always_comb begin
      claimed = pending;
      if (r_valid && r_writes_dst)
         claimed[r_dst] = 1'b1;
   end

   assign stall   = (d_uses_src & claimed[d_src]) | (d_writes_dst & claimed[d_dst]);
   assign d_ready = (~r_valid | r_ready) & ~stall;
   assign d_xfer  = d_valid & d_ready;
   assign r_xfer  = r_valid & r_ready & ~redirect;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_valid) begin
         regs[wb_reg] <= wb_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_valid <= 1'b0;
         pending <= '0;
      end else begin
         if (redirect)
            r_valid <= 1'b0;
         else if (~r_valid | r_ready)
            r_valid <= d_xfer & (d_writes_dst | d_jump);  // NOPs drop out here

         if (wb_valid)
            pending[wb_reg] <= 1'b0;
         if (r_xfer && r_writes_dst)
            pending[r_dst] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (d_xfer) begin
         r_alu_op     <= d_alu_op;
         r_dst        <= d_dst;
         r_writes_dst <= d_writes_dst;
         r_jump       <= d_jump;
         r_op_a       <= regs[d_dst];
         r_op_b       <= d_use_imm ? d_imm : regs[d_src];
         r_pc         <= d_pc;
      end
   end

   // Writeback must belong to an instruction the scoreboard tracked
   a_wb_was_pending: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid |-> pending[wb_reg]);

endmodule

`default_nettype wire

// File: src/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              r_valid,
   output logic              r_ready,
   input  cpu_pkg::alu_op_e  r_alu_op,
   input  cpu_pkg::reg_idx_t r_dst,
   input  logic              r_writes_dst,
   input  logic              r_jump,
   input  cpu_pkg::word_t    r_op_a,
   input  cpu_pkg::word_t    r_op_b,
   input  cpu_pkg::addr_t    r_pc,
   output logic              wb_valid,
   output cpu_pkg::reg_idx_t wb_reg,
   output cpu_pkg::word_t    wb_data,
   output logic              redirect,
   output cpu_pkg::addr_t    redirect_address
);
   import cpu_pkg::*;

   word_t result;
   addr_t target;
   logic  accept;

   assign r_ready = 1'b1;
   // Entry behind a taken jump is dropped
   assign accept  = r_valid & r_ready & ~redirect;

   always_comb begin
      case (r_alu_op)
         ALU_ADD: result = r_op_a + r_op_b;
         ALU_SUB: result = r_op_a - r_op_b;
         ALU_AND: result = r_op_a & r_op_b;
         ALU_OR:  result = r_op_a | r_op_b;
         ALU_XOR: result = r_op_a ^ r_op_b;
         default: result = r_op_b;   // mov
      endcase
   end

   // Offset is in words from the next instruction
   assign target = r_pc + addr_t'(INSTR_BYTES) + r_op_b * addr_t'(INSTR_BYTES);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
         redirect <= 1'b0;
      end else begin
         wb_valid <= accept & r_writes_dst;
         redirect <= accept & r_jump;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         wb_reg           <= r_dst;
         wb_data          <= result;
         redirect_address <= target;
      end
   end

   // A jump never writes a register
   a_redirect_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
      redirect |-> !wb_valid);

endmodule

`default_nettype wire

// File: src/pipeline_top.sv
`timescale 1ns/100ps
`default_nettype none

module pipeline_top (
   input  logic              clk,
   input  logic              rst_n,
   output logic              imem_valid,
   input  logic              imem_ready,
   output cpu_pkg::addr_t    imem_address,
   input  logic              imem_dp_valid,
   output logic              imem_dp_ready,
   input  cpu_pkg::word_t    imem_dp_read_data,
   output logic              retire_valid,
   output cpu_pkg::reg_idx_t retire_reg,
   output cpu_pkg::word_t    retire_data
);
   import cpu_pkg::*;

   logic     redirect;
   addr_t    redirect_address;

   // Fetch to decode
   logic     f_valid;
   logic     f_ready;
   word_t    f_instruction;
   addr_t    f_pc;

   // Decode to register access
   logic     d_valid;
   logic     d_ready;
   alu_op_e  d_alu_op;
   reg_idx_t d_dst;
   reg_idx_t d_src;
   logic     d_uses_src;
   logic     d_writes_dst;
   logic     d_use_imm;
   logic     d_jump;
   word_t    d_imm;
   addr_t    d_pc;

   // Register access to execute
   logic     r_valid;
   logic     r_ready;
   alu_op_e  r_alu_op;
   reg_idx_t r_dst;
   logic     r_writes_dst;
   logic     r_jump;
   word_t    r_op_a;
   word_t    r_op_b;
   addr_t    r_pc;

   logic     wb_valid;
   reg_idx_t wb_reg;
   word_t    wb_data;

   fetch_unit uut_fetch (
      .clk, .rst_n, .redirect, .redirect_address,
      .imem_valid, .imem_ready, .imem_address,
      .imem_dp_valid, .imem_dp_ready, .imem_dp_read_data,
      .f_valid, .f_ready, .f_instruction, .f_pc
   );

   decode_unit uut_decode (
      .clk, .rst_n, .redirect,
      .f_valid, .f_ready, .f_instruction, .f_pc,
      .d_valid, .d_ready, .d_alu_op, .d_dst, .d_src,
      .d_uses_src, .d_writes_dst, .d_use_imm, .d_jump, .d_imm, .d_pc
   );

   register_access uut_register_access (
      .clk, .rst_n, .redirect,
      .d_valid, .d_ready, .d_alu_op, .d_dst, .d_src,
      .d_uses_src, .d_writes_dst, .d_use_imm, .d_jump, .d_imm, .d_pc,
      .r_valid, .r_ready, .r_alu_op, .r_dst, .r_writes_dst, .r_jump,
      .r_op_a, .r_op_b, .r_pc,
      .wb_valid, .wb_reg, .wb_data
   );

   execute_unit uut_execute (
      .clk, .rst_n,
      .r_valid, .r_ready, .r_alu_op, .r_dst, .r_writes_dst, .r_jump,
      .r_op_a, .r_op_b, .r_pc,
      .wb_valid, .wb_reg, .wb_data, .redirect, .redirect_address
   );

   assign retire_valid = wb_valid;   // Every register write retires
   assign retire_reg   = wb_reg;
   assign retire_data  = wb_data;

endmodule

`default_nettype wire

// File: verif/tb_imem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_imem #(
   parameter int WORDS = 1024
) (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           imem_valid,
   output logic           imem_ready,
   input  cpu_pkg::addr_t imem_address,
   output logic           imem_dp_valid,
   input  logic           imem_dp_ready,
   output cpu_pkg::word_t imem_dp_read_data
);
   import cpu_pkg::*;

   localparam int IDX_BITS = $clog2(WORDS);

   word_t mem [WORDS];          // Loaded by the testbench top
   addr_t pending_q [$];        // Accepted requests in arrival order
   addr_t resp_addr;
   int    req_delay;
   int    ready_wait = 0;
   int    resp_wait  = 0;
   logic  ready_r    = 1'b0;
   logic  dp_valid_r = 1'b0;
   word_t dp_data_r  = '0;

   assign imem_ready        = ready_r;
   assign imem_dp_valid     = dp_valid_r;
   assign imem_dp_read_data = dp_data_r;

   always @(posedge clk) begin
      if (!rst_n) begin
         ready_r    <= 1'b0;
         dp_valid_r <= 1'b0;
         ready_wait <= 0;
         resp_wait  <= 0;
         pending_q.delete();
      end else begin
         // Ready stays low for 0 to 3 cycles after a request transfer
         if (imem_valid && ready_r) begin
            pending_q.push_back(imem_address);
            req_delay = $urandom_range(0, 3);
            ready_r    <= (req_delay == 0);
            ready_wait <= req_delay;
         end else if (!ready_r) begin
            if (ready_wait <= 1)
               ready_r <= 1'b1;
            ready_wait <= ready_wait - 1;
         end

         // Responses leave in request order
         if (dp_valid_r && imem_dp_ready) begin
            dp_valid_r <= 1'b0;
            resp_wait  <= $urandom_range(0, 3);
         end else if (!dp_valid_r && pending_q.size() > 0) begin
            if (resp_wait == 0) begin
               resp_addr = pending_q.pop_front();
               dp_valid_r <= 1'b1;
               dp_data_r  <= mem[resp_addr[IDX_BITS+1:2]];
            end else begin
               resp_wait <= resp_wait - 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verif/tb_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pipeline;
   import cpu_pkg::*;

   localparam int PROG_WORDS       = 1024;
   localparam int IDX_BITS         = $clog2(PROG_WORDS);
   localparam int NUM_CHECKS       = 300;
   localparam int CLK_PERIOD       = 20;
   localparam int RESET_CYCLES     = 16;
   localparam int CYCLES_PER_INSTR = 40;
   localparam int WATCHDOG_NS      = (RESET_CYCLES + NUM_CHECKS * CYCLES_PER_INSTR) * CLK_PERIOD;

   logic     clk   = 1'b0;
   logic     rst_n = 1'b0;
   logic     imem_valid;
   logic     imem_ready;
   addr_t    imem_address;
   logic     imem_dp_valid;
   logic     imem_dp_ready;
   word_t    imem_dp_read_data;
   logic     retire_valid;
   reg_idx_t retire_reg;
   word_t    retire_data;

   word_t    program_words [PROG_WORDS];
   reg_idx_t exp_reg_q [$];
   word_t    exp_data_q [$];
   int       retired        = 0;
   logic     first_req_seen = 1'b0;

   pipeline_top uut (
      .clk, .rst_n,
      .imem_valid, .imem_ready, .imem_address,
      .imem_dp_valid, .imem_dp_ready, .imem_dp_read_data,
      .retire_valid, .retire_reg, .retire_data
   );

   tb_imem #(.WORDS(PROG_WORDS)) imem_model (
      .clk, .rst_n,
      .imem_valid, .imem_ready, .imem_address,
      .imem_dp_valid, .imem_dp_ready, .imem_dp_read_data
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_reg(input reg_idx_t actual, input reg_idx_t expected, input string name);
      if (actual !== expected)
         abort_run($sformatf("FAILED at %0t ns: %s = %0d, expected %0d",
                             $time, name, actual, expected));
   endtask

   task automatic check_data(input word_t actual, input word_t expected, input string name);
      if (actual !== expected)
         abort_run($sformatf("FAILED at %0t ns: %s = %h, expected %h",
                             $time, name, actual, expected));
   endtask

   task automatic check_addr(input addr_t actual, input addr_t expected, input string name);
      if (actual !== expected)
         abort_run($sformatf("FAILED at %0t ns: %s = %h, expected %h",
                             $time, name, actual, expected));
   endtask

   function automatic word_t encode(input logic [3:0] opc, input reg_idx_t dst,
                                    input reg_idx_t src, input logic [15:0] imm,
                                    input word_t filler);
      word_t w;
      w = filler;                       // Unused bits carry junk
      w[OPC_MSB:OPC_LSB] = opc;
      w[DST_MSB:DST_LSB] = dst;
      w[SRC_MSB:SRC_LSB] = src;
      w[IMM_MSB:IMM_LSB] = imm;
      return w;
   endfunction

   task automatic build_program();
      logic [3:0]  opc;
      reg_idx_t    dst;
      reg_idx_t    src;
      reg_idx_t    last_dst;
      logic [15:0] imm;
      last_dst = '0;
      for (int i = 0; i < PROG_WORDS; i++) begin
         opc = 4'($urandom_range(0, 11));
         if (opc > 4'd9)
            opc = 4'($urandom_range(10, 15));   // Unused codes act as NOP
         dst = 3'($urandom_range(0, 7));
         // Half the sources chain on the previous result
         src = ($urandom_range(0, 1) == 1) ? last_dst : 3'($urandom_range(0, 7));
         imm = 16'($urandom());
         if (opc == OP_JMP)
            imm = 16'($urandom_range(0, 3));  // Forward only
         program_words[i] = encode(opc, dst, src, imm, $urandom());
         last_dst = dst;
      end
   endtask

   // Instruction set model running in program order from RESET_PC
   task automatic run_model();
      word_t    model_regs [NUM_REGS];
      addr_t    pc;
      word_t    instr;
      word_t    imm;
      word_t    res;
      reg_idx_t dst;
      reg_idx_t src;
      logic     writes;
      int       steps;
      for (int r = 0; r < NUM_REGS; r++)
         model_regs[r] = '0;
      pc    = RESET_PC;
      steps = 0;
      while (exp_data_q.size() < NUM_CHECKS && steps < 100 * PROG_WORDS) begin
         instr  = program_words[pc[IDX_BITS+1:2]];
         dst    = instr[DST_MSB:DST_LSB];
         src    = instr[SRC_MSB:SRC_LSB];
         imm    = word_t'($signed(instr[IMM_MSB:IMM_LSB]));
         res    = '0;
         writes = 1'b1;
         pc     = pc + addr_t'(INSTR_BYTES);
         case (instr[OPC_MSB:OPC_LSB])
            OP_MOV_RR: res = model_regs[src];
            OP_MOV_RI: res = imm;
            OP_ADD:    res = model_regs[dst] + model_regs[src];
            OP_ADD_RI: res = model_regs[dst] + imm;
            OP_SUB:    res = model_regs[dst] - model_regs[src];
            OP_AND:    res = model_regs[dst] & model_regs[src];
            OP_OR:     res = model_regs[dst] | model_regs[src];
            OP_XOR:    res = model_regs[dst] ^ model_regs[src];
            OP_JMP: begin
               pc     = pc + imm * addr_t'(INSTR_BYTES);
               writes = 1'b0;
            end
            default: writes = 1'b0;
         endcase
         if (writes) begin
            model_regs[dst] = res;
            exp_reg_q.push_back(dst);
            exp_data_q.push_back(res);
         end
         steps++;
      end
      if (exp_data_q.size() < NUM_CHECKS)
         abort_run("The generated program does not retire enough instructions");
   endtask

   initial begin
      void'($urandom(52));
      build_program();
      for (int i = 0; i < PROG_WORDS; i++)
         imem_model.mem[i] = program_words[i];
      run_model();
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

   // Reset, first request and retirement checks
   always @(negedge clk) begin
      if (!rst_n) begin
         if (retire_valid === 1'b1 || imem_valid === 1'b1)
            abort_run("A request or a retirement appeared while reset was asserted");
      end else begin
         if (imem_valid && imem_ready && !first_req_seen) begin
            check_addr(imem_address, RESET_PC, "imem_address");
            first_req_seen = 1'b1;
         end
         if (retire_valid) begin
            check_reg(retire_reg, exp_reg_q.pop_front(), "retire_reg");
            check_data(retire_data, exp_data_q.pop_front(), "retire_data");
            retired++;
            if (retired == NUM_CHECKS) begin
               $display("%0d retirements checked", retired);
               $display("Simulation PASSED");
               $finish;
            end
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      abort_run($sformatf("Timeout: retirements stopped after %0d of %0d", retired, NUM_CHECKS));
   end

endmodule

`default_nettype wire

// File: tb.f
src/cpu_pkg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/register_access.sv
src/execute_unit.sv
src/pipeline_top.sv
verif/tb_imem.sv
verif/tb_pipeline.sv

// File: Makefile
TOP := tb_pipeline

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

obj_dir/V$(TOP): tb.f src/*.sv verif/*.sv
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
